/* tb.f */
+incdir+.
rename_pkg.sv
rename_map.sv
free_list.sv
reorder_buffer.sv
retire_stage.sv
arch_map_table.sv
rename_core.sv
rename_checker.sv
tb_rename_core.sv

/* Bender.yml */
package:
  name: rename_core

sources:
  - include_dirs:
      - .
    files:
      - rename_pkg.sv
      - rename_map.sv
      - free_list.sv
      - reorder_buffer.sv
      - retire_stage.sv
      - arch_map_table.sv
      - rename_core.sv
  - target: test
    include_dirs:
      - .
    files:
      - rename_checker.sv
      - tb_rename_core.sv

/* tb_rename_core.sv */
`timescale 1ns/10ps
`include "rename_defines.svh"
`default_nettype none

module tb_rename_core import rename_pkg::*; ();

    localparam int W          = `RN_WIDTH;
    localparam int NUM_GROUPS = 2500;
    localparam int MAX_CYCLES = NUM_GROUPS * 4 + 500; // Completion is one per cycle, plus holds.

    typedef struct packed {
        rob_idx_t    idx;
        inst_class_e cls;
        arch_idx_t   rd;
        phys_idx_t   pnew;
        phys_idx_t   pold;
        logic        done;
    } rob_ent_t;

    logic                     clk;
    logic                     rst_n_i;
    logic [W-1:0]             ren_valid_i;
    inst_class_e [W-1:0]      ren_class_i;
    arch_idx_t [W-1:0]        ren_rd_i, ren_rs1_i, ren_rs2_i;
    logic                     complete_valid_i;
    rob_idx_t                 complete_idx_i;
    logic                     flush_i;
    logic                     ren_ready_o;
    phys_idx_t [W-1:0]        ren_prd_o, ren_prs1_o, ren_prs2_o;
    rob_idx_t [W-1:0]         ren_rob_idx_o;
    logic [W-1:0]             commit_valid_o;
    arch_idx_t [W-1:0]        commit_arch_o;
    phys_idx_t [W-1:0]        commit_phys_o;
    logic [W-1:0]             free_valid_o;
    phys_idx_t [W-1:0]        free_reg_o;
    logic [RET_CNT_W-1:0]     retire_cnt_o;

    // Reference model state.
    phys_idx_t                spec_map [`RN_ARCH_REGS];
    phys_idx_t                arch_map [`RN_ARCH_REGS];
    logic [`RN_PHYS_REGS-1:0] allocated;
    rob_ent_t                 outstanding [$];
    rob_idx_t                 tail;

    // Inputs of the current cycle and the outputs the model expects for it.
    logic [W-1:0]             v_valid;
    inst_class_e [W-1:0]      v_cls;
    arch_idx_t [W-1:0]        v_rd, v_rs1, v_rs2;
    logic                     v_cvalid;
    rob_idx_t                 v_cidx;
    logic                     v_flush;
    logic                     exp_ready;
    logic [W-1:0]             exp_req;
    phys_idx_t [W-1:0]        exp_prd, exp_old, exp_prs1, exp_prs2;
    rob_idx_t [W-1:0]         exp_rob_idx;
    logic [W-1:0]             exp_cvalid;
    arch_idx_t [W-1:0]        exp_carch;
    phys_idx_t [W-1:0]        exp_cphys, exp_free;
    logic [RET_CNT_W-1:0]     exp_ret_cnt;

    integer                   seed;
    int                       groups;
    int                       hold_cnt;
    bit                       first_grp;

    rename_core UUT (.*);

    bind rename_core rename_checker u_checker (
        .*,
        .exp_ready_i   (tb_rename_core.exp_ready),
        .exp_req_i     (tb_rename_core.exp_req),
        .exp_alloc_i   (tb_rename_core.allocated),
        .exp_prd_i     (tb_rename_core.exp_prd),
        .exp_prs1_i    (tb_rename_core.exp_prs1),
        .exp_prs2_i    (tb_rename_core.exp_prs2),
        .exp_rob_idx_i (tb_rename_core.exp_rob_idx),
        .exp_cvalid_i  (tb_rename_core.exp_cvalid),
        .exp_carch_i   (tb_rename_core.exp_carch),
        .exp_cphys_i   (tb_rename_core.exp_cphys),
        .exp_free_i    (tb_rename_core.exp_free),
        .exp_ret_cnt_i (tb_rename_core.exp_ret_cnt)
    );

    function automatic int unsigned rnd(input int unsigned n);
        return $unsigned($random(seed)) % n;
    endfunction

    function automatic arch_idx_t pick_reg();
        return arch_idx_t'((rnd(2) != 0) ? rnd(8) : rnd(32)); // Small range makes forwarding common.
    endfunction

    function automatic bit has_dest(input inst_class_e c);
        return (c == CLS_ALU) || (c == CLS_LOAD);
    endfunction

    // Number of oldest entries that are done without a gap, up to the commit width.
    function automatic int done_prefix();
        int n;
        n = 0;
        while ((n < W) && (n < outstanding.size()) && outstanding[n].done) begin
            n++;
        end
        return n;
    endfunction

    task automatic flush_model();
        allocated = '0;
        for (int i = 0; i < `RN_ARCH_REGS; i++) begin
            spec_map[i]          = arch_map[i];
            allocated[arch_map[i]] = 1'b1;
        end
        outstanding.delete();
        tail = '0;
    endtask

    task automatic update_model();
        int n;
        if (v_flush) begin
            flush_model();
        end else begin
            n = done_prefix();
            for (int k = 0; k < n; k++) begin
                if (has_dest(outstanding[k].cls)) begin
                    arch_map[outstanding[k].rd] = outstanding[k].pnew;
                    allocated[outstanding[k].pold] = 1'b0;
                end
            end
            repeat (n) begin
                void'(outstanding.pop_front());
            end
            foreach (outstanding[i]) begin
                if (v_cvalid && (outstanding[i].idx == v_cidx)) begin
                    outstanding[i].done = 1'b1;
                end
            end
            if (exp_ready && (|v_valid)) begin
                for (int s = 0; s < W; s++) begin
                    if (v_valid[s]) begin
                        outstanding.push_back('{exp_rob_idx[s], v_cls[s], v_rd[s],
                                                exp_prd[s], exp_old[s], 1'b0});
                        tail++;
                    end
                    if (exp_req[s]) begin
                        allocated[exp_prd[s]] = 1'b1;
                        spec_map[v_rd[s]]     = exp_prd[s]; // Slot 1 lands last.
                    end
                end
                groups++;
            end
        end
    endtask

    task automatic pick_inputs();
        int start;
        int k;
        v_flush   = (rnd(150) == 0);
        exp_ready = ((`RN_ROB_DEPTH - outstanding.size()) >= W) &&
                    ((`RN_PHYS_REGS - $countones(allocated)) >= W) && !v_flush;
        for (int s = 0; s < W; s++) begin
            v_valid[s] = exp_ready && (rnd(4) != 0);
            v_cls[s]   = inst_class_e'(rnd(4));
            v_rd[s]    = pick_reg();
            v_rs1[s]   = pick_reg();
            v_rs2[s]   = pick_reg();
        end
        if (first_grp && exp_ready) begin
            v_valid   = W'(1);
            v_cls[0]  = CLS_ALU;
            first_grp = 1'b0;
        end
        // Completions pause now and then so that the buffer fills up.
        if (hold_cnt > 0) begin
            hold_cnt--;
        end else if (rnd(200) == 0) begin
            hold_cnt = 40;
        end
        v_cvalid = 1'b0;
        v_cidx   = '0;
        if ((hold_cnt == 0) && (outstanding.size() > 0) && (rnd(8) != 0)) begin
            start = rnd(outstanding.size());
            for (int i = 0; i < outstanding.size(); i++) begin
                k = (start + i) % outstanding.size();
                if (!v_cvalid && !outstanding[k].done) begin
                    v_cvalid = 1'b1;
                    v_cidx   = outstanding[k].idx;
                end
            end
        end
    endtask

    task automatic drive_inputs();
        ren_valid_i      <= v_valid;
        ren_class_i      <= v_cls;
        ren_rd_i         <= v_rd;
        ren_rs1_i        <= v_rs1;
        ren_rs2_i        <= v_rs2;
        complete_valid_i <= v_cvalid;
        complete_idx_i   <= v_cidx;
        flush_i          <= v_flush;
    endtask

    task automatic predict_outputs();
        int p;
        int n;
        p = 0;
        n = 0;
        for (int s = 0; s < W; s++) begin
            exp_req[s]     = v_valid[s] && has_dest(v_cls[s]);
            exp_rob_idx[s] = tail + rob_idx_t'(n);
            n              = n + int'(v_valid[s]);
            exp_prd[s]     = '0;
            if (exp_req[s]) begin
                while ((p < `RN_PHYS_REGS - 1) && allocated[p]) begin
                    p++;
                end
                exp_prd[s] = phys_idx_t'(p);
                p++;
            end
            exp_prs1[s] = spec_map[v_rs1[s]];
            exp_prs2[s] = spec_map[v_rs2[s]];
            exp_old[s]  = spec_map[v_rd[s]];
            for (int j = 0; j < s; j++) begin
                if (exp_req[j] && (v_rd[j] == v_rs1[s])) exp_prs1[s] = exp_prd[j];
                if (exp_req[j] && (v_rd[j] == v_rs2[s])) exp_prs2[s] = exp_prd[j];
                if (exp_req[j] && (v_rd[j] == v_rd[s]))  exp_old[s]  = exp_prd[j];
            end
        end
        n           = done_prefix();
        exp_ret_cnt = '0;
        for (int k = 0; k < W; k++) begin
            exp_cvalid[k] = 1'b0;
            if ((k < n) && has_dest(outstanding[k].cls) && !v_flush) begin
                exp_cvalid[k] = 1'b1;
                exp_carch[k]  = outstanding[k].rd;
                exp_cphys[k]  = outstanding[k].pnew;
                exp_free[k]   = outstanding[k].pold;
                exp_ret_cnt   = exp_ret_cnt + 1'b1;
            end
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    initial begin
        seed      = 32'hbe3f;
        groups    = 0;
        hold_cnt  = 0;
        first_grp = 1'b1;
        v_valid   = '0;
        v_rd      = '0;
        v_rs1     = '0;
        v_rs2     = '0;
        v_cvalid  = 1'b0;
        v_cidx    = '0;
        v_flush   = 1'b0;
        exp_ready = 1'b1; // An empty core accepts a group as soon as reset ends.
        for (int s = 0; s < W; s++) begin
            v_cls[s] = CLS_ALU;
        end
        rst_n_i <= 1'b0;
        drive_inputs();
        for (int i = 0; i < `RN_ARCH_REGS; i++) begin
            arch_map[i] = phys_idx_t'(i);
        end
        flush_model(); // Identity maps, upper registers free.
        predict_outputs();
        repeat (10) @(posedge clk);
        rst_n_i <= 1'b1;
        while (groups < NUM_GROUPS) begin
            pick_inputs();
            drive_inputs();
            predict_outputs();
            @(posedge clk);
            update_model();
        end
        @(negedge clk);
        if (UUT.u_checker.err_cnt != 0) begin
            $display("*** FAILED ***");
            $fatal(1, "Checker assertions failed during the run.");
        end else begin
            $display("*** PASSED ***");
            $finish;
        end
    end

    // Stop at the first failed assertion.
    initial begin
        wait (UUT.u_checker.err_cnt != 0);
        $display("*** FAILED ***");
        $fatal(1, "A checker assertion failed, stopping the run.");
    end

    initial begin
        repeat (MAX_CYCLES) @(posedge clk);
        $display("*** FAILED ***");
        $fatal(1, "Watchdog expired before %0d rename groups were accepted.", NUM_GROUPS);
    end

endmodule

`default_nettype wire

/* rename_checker.sv */
`timescale 1ns/10ps
`include "rename_defines.svh"
`default_nettype none

module rename_checker import rename_pkg::*; (
    input logic                      clk,
    input logic                      rst_n_i,
    input logic                      flush_i,
    input logic [`RN_WIDTH-1:0]      ren_valid_i,
    input logic                      ren_ready_o,
    input phys_idx_t [`RN_WIDTH-1:0] ren_prd_o,
    input phys_idx_t [`RN_WIDTH-1:0] ren_prs1_o,
    input phys_idx_t [`RN_WIDTH-1:0] ren_prs2_o,
    input rob_idx_t [`RN_WIDTH-1:0]  ren_rob_idx_o,
    input logic [`RN_WIDTH-1:0]      commit_valid_o,
    input arch_idx_t [`RN_WIDTH-1:0] commit_arch_o,
    input phys_idx_t [`RN_WIDTH-1:0] commit_phys_o,
    input logic [`RN_WIDTH-1:0]      free_valid_o,
    input phys_idx_t [`RN_WIDTH-1:0] free_reg_o,
    input logic [RET_CNT_W-1:0]      retire_cnt_o,
    input logic                      exp_ready_i,
    input logic [`RN_WIDTH-1:0]      exp_req_i,
    input logic [`RN_PHYS_REGS-1:0]  exp_alloc_i,
    input phys_idx_t [`RN_WIDTH-1:0] exp_prd_i,
    input phys_idx_t [`RN_WIDTH-1:0] exp_prs1_i,
    input phys_idx_t [`RN_WIDTH-1:0] exp_prs2_i,
    input rob_idx_t [`RN_WIDTH-1:0]  exp_rob_idx_i,
    input logic [`RN_WIDTH-1:0]      exp_cvalid_i,
    input arch_idx_t [`RN_WIDTH-1:0] exp_carch_i,
    input phys_idx_t [`RN_WIDTH-1:0] exp_cphys_i,
    input phys_idx_t [`RN_WIDTH-1:0] exp_free_i,
    input logic [RET_CNT_W-1:0]      exp_ret_cnt_i
);

    int err_cnt = 0;

    a_ready: assert property (@(posedge clk) disable iff (!rst_n_i)
        ren_ready_o == exp_ready_i)
        else begin
            $error("Error at %0t: rename ready differs from model", $time);
            err_cnt++;
        end

    // Nothing retires and nothing renames while the pipeline is being flushed.
    a_flush: assert property (@(posedge clk) disable iff (!rst_n_i)
        flush_i |-> (!ren_ready_o && (commit_valid_o == '0) && (free_valid_o == '0)))
        else begin
            $error("Error at %0t: activity during flush", $time);
            err_cnt++;
        end

    a_commit_valid: assert property (@(posedge clk) disable iff (!rst_n_i)
        (commit_valid_o == exp_cvalid_i) && (free_valid_o == exp_cvalid_i) &&
        (retire_cnt_o == exp_ret_cnt_i))
        else begin
            $error("Error at %0t: commit valids or retire count wrong", $time);
            err_cnt++;
        end

    a_distinct: assert property (@(posedge clk) disable iff (!rst_n_i)
        (ren_ready_o && (&exp_req_i)) |-> (ren_prd_o[0] != ren_prd_o[1]))
        else begin
            $error("Error at %0t: same register given to both slots", $time);
            err_cnt++;
        end

    for (genvar l = 0; l < `RN_WIDTH; l++) begin : g_lane
        a_prd: assert property (@(posedge clk) disable iff (!rst_n_i)
            (ren_ready_o && exp_req_i[l]) |->
                ((ren_prd_o[l] == exp_prd_i[l]) && !exp_alloc_i[ren_prd_o[l]]))
            else begin
                $error("Error at %0t: bad destination in slot %0d", $time, l);
                err_cnt++;
            end

        a_src: assert property (@(posedge clk) disable iff (!rst_n_i)
            (ren_ready_o && ren_valid_i[l]) |->
                ((ren_prs1_o[l] == exp_prs1_i[l]) && (ren_prs2_o[l] == exp_prs2_i[l]) &&
                 (ren_rob_idx_o[l] == exp_rob_idx_i[l])))
            else begin
                $error("Error at %0t: source or ROB index in slot %0d", $time, l);
                err_cnt++;
            end

        a_commit: assert property (@(posedge clk) disable iff (!rst_n_i)
            commit_valid_o[l] |->
                ((commit_arch_o[l] == exp_carch_i[l]) && (commit_phys_o[l] == exp_cphys_i[l]) &&
                 (free_reg_o[l] == exp_free_i[l])))
            else begin
                $error("Error at %0t: commit data in lane %0d", $time, l);
                err_cnt++;
            end
    end

endmodule

`default_nettype wire

/* rename_core.sv */
`timescale 1ns/10ps
`include "rename_defines.svh"
`default_nettype none

module rename_core import rename_pkg::*; (
    input  logic                        clk,
    input  logic                        rst_n_i,
    input  logic [`RN_WIDTH-1:0]        ren_valid_i,
    input  inst_class_e [`RN_WIDTH-1:0] ren_class_i,
    input  arch_idx_t [`RN_WIDTH-1:0]   ren_rd_i,
    input  arch_idx_t [`RN_WIDTH-1:0]   ren_rs1_i,
    input  arch_idx_t [`RN_WIDTH-1:0]   ren_rs2_i,
    input  logic                        complete_valid_i,
    input  rob_idx_t                    complete_idx_i,
    input  logic                        flush_i,
    output logic                        ren_ready_o,
    output phys_idx_t [`RN_WIDTH-1:0]   ren_prd_o,
    output phys_idx_t [`RN_WIDTH-1:0]   ren_prs1_o,
    output phys_idx_t [`RN_WIDTH-1:0]   ren_prs2_o,
    output rob_idx_t [`RN_WIDTH-1:0]    ren_rob_idx_o,
    output logic [`RN_WIDTH-1:0]        commit_valid_o,
    output arch_idx_t [`RN_WIDTH-1:0]   commit_arch_o,
    output phys_idx_t [`RN_WIDTH-1:0]   commit_phys_o,
    output logic [`RN_WIDTH-1:0]        free_valid_o,
    output phys_idx_t [`RN_WIDTH-1:0]   free_reg_o,
    output logic [RET_CNT_W-1:0]        retire_cnt_o
);

    logic                          ren_fire;
    logic [`RN_WIDTH-1:0]          fl_alloc_req;
    phys_idx_t [`RN_WIDTH-1:0]     fl_alloc_prd;
    phys_idx_t [`RN_WIDTH-1:0]     ren_old_prd;
    logic [ROB_CNT_W-1:0]          rob_free_cnt;
    logic [FREE_CNT_W-1:0]         fl_free_cnt;
    phys_idx_t [`RN_ARCH_REGS-1:0] amt_map;
    logic [`RN_PHYS_REGS-1:0]      held_mask;
    logic [`RN_WIDTH-1:0]          head_valid;
    logic [`RN_WIDTH-1:0]          head_rd_wen;
    arch_idx_t [`RN_WIDTH-1:0]     head_arch;
    phys_idx_t [`RN_WIDTH-1:0]     head_new;
    phys_idx_t [`RN_WIDTH-1:0]     head_old;

    rename_map u_rename_map (
        .clk, .rst_n_i, .flush_i,
        .ren_valid_i, .ren_class_i, .ren_rd_i, .ren_rs1_i, .ren_rs2_i,
        .rob_free_cnt_i (rob_free_cnt),
        .fl_free_cnt_i  (fl_free_cnt),
        .amt_map_i      (amt_map),
        .fl_alloc_prd_i (fl_alloc_prd),
        .ren_ready_o,
        .ren_fire_o     (ren_fire),
        .fl_alloc_req_o (fl_alloc_req),
        .ren_prd_o,
        .ren_old_prd_o  (ren_old_prd),
        .ren_prs1_o, .ren_prs2_o
    );

    free_list u_free_list (
        .clk, .rst_n_i, .flush_i,
        .alloc_req_i  (fl_alloc_req),
        .alloc_fire_i (ren_fire),
        .alloc_prd_o  (fl_alloc_prd),
        .free_valid_i (free_valid_o),
        .free_reg_i   (free_reg_o),
        .held_mask_i  (held_mask),
        .free_cnt_o   (fl_free_cnt)
    );

    reorder_buffer u_reorder_buffer (
        .clk, .rst_n_i, .flush_i, .complete_valid_i, .complete_idx_i,
        .alloc_fire_i  (ren_fire),
        .alloc_valid_i (ren_valid_i),
        .alloc_class_i (ren_class_i),
        .alloc_rd_i    (ren_rd_i),
        .alloc_new_i   (ren_prd_o),
        .alloc_old_i   (ren_old_prd),
        .alloc_idx_o   (ren_rob_idx_o),
        .free_cnt_o    (rob_free_cnt),
        .head_valid_o  (head_valid),
        .head_rd_wen_o (head_rd_wen),
        .head_arch_o   (head_arch),
        .head_new_o    (head_new),
        .head_old_o    (head_old)
    );

    retire_stage u_retire_stage (
        .head_valid_i  (head_valid),
        .head_rd_wen_i (head_rd_wen),
        .head_arch_i   (head_arch),
        .head_new_i    (head_new),
        .head_old_i    (head_old),
        .flush_i,
        .amt_valid_o   (commit_valid_o),
        .amt_arch_o    (commit_arch_o),
        .amt_phys_o    (commit_phys_o),
        .free_valid_o, .free_reg_o, .retire_cnt_o
    );

    arch_map_table u_arch_map_table (
        .clk, .rst_n_i,
        .amt_valid_i (commit_valid_o),
        .amt_arch_i  (commit_arch_o),
        .amt_phys_i  (commit_phys_o),
        .amt_map_o   (amt_map),
        .held_mask_o (held_mask)
    );

endmodule

`default_nettype wire

/* arch_map_table.sv */
`timescale 1ns/10ps
`include "rename_defines.svh"
`default_nettype none

module arch_map_table import rename_pkg::*; (
    input  logic                          clk,
    input  logic                          rst_n_i,
    input  logic [`RN_WIDTH-1:0]          amt_valid_i,
    input  arch_idx_t [`RN_WIDTH-1:0]     amt_arch_i,
    input  phys_idx_t [`RN_WIDTH-1:0]     amt_phys_i,
    output phys_idx_t [`RN_ARCH_REGS-1:0] amt_map_o,
    output logic [`RN_PHYS_REGS-1:0]      held_mask_o
);

    phys_idx_t [`RN_ARCH_REGS-1:0] map_q;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            for (int i = 0; i < `RN_ARCH_REGS; i++) begin
                map_q[i] <= phys_idx_t'(i);
            end
        end else begin
            for (int l = 0; l < `RN_WIDTH; l++) begin
                if (amt_valid_i[l]) begin
                    map_q[amt_arch_i[l]] <= amt_phys_i[l]; // Younger lane lands last.
                end
            end
        end
    end

    assign amt_map_o = map_q;

    // Physical registers named by the committed map are never free.
    always_comb begin
        held_mask_o = '0;
        for (int i = 0; i < `RN_ARCH_REGS; i++) begin
            held_mask_o[map_q[i]] = 1'b1;
        end
    end

endmodule

`default_nettype wire

/* retire_stage.sv */
`timescale 1ns/10ps
`include "rename_defines.svh"
`default_nettype none

module retire_stage import rename_pkg::*; (
    input  logic [`RN_WIDTH-1:0]      head_valid_i,
    input  logic [`RN_WIDTH-1:0]      head_rd_wen_i,
    input  arch_idx_t [`RN_WIDTH-1:0] head_arch_i,
    input  phys_idx_t [`RN_WIDTH-1:0] head_new_i,
    input  phys_idx_t [`RN_WIDTH-1:0] head_old_i,
    input  logic                      flush_i,
    output logic [`RN_WIDTH-1:0]      amt_valid_o,
    output arch_idx_t [`RN_WIDTH-1:0] amt_arch_o,
    output phys_idx_t [`RN_WIDTH-1:0] amt_phys_o,
    output logic [`RN_WIDTH-1:0]      free_valid_o,
    output phys_idx_t [`RN_WIDTH-1:0] free_reg_o,
    output logic [RET_CNT_W-1:0]      retire_cnt_o
);

    logic [`RN_WIDTH-1:0] fire;

    // A flush cancels every lane of this cycle.
    assign fire = head_valid_i & head_rd_wen_i & {`RN_WIDTH{~flush_i}};

    always_comb begin
        amt_valid_o  = fire;
        free_valid_o = fire;
        retire_cnt_o = '0;
        for (int l = 0; l < `RN_WIDTH; l++) begin
            amt_arch_o[l] = fire[l] ? head_arch_i[l] : '0;
            amt_phys_o[l] = fire[l] ? head_new_i[l] : '0;
            free_reg_o[l] = fire[l] ? head_old_i[l] : '0; // Previous owner of the arch reg.
            retire_cnt_o  = retire_cnt_o + RET_CNT_W'(fire[l]);
        end
    end

endmodule

`default_nettype wire

/* reorder_buffer.sv */
`timescale 1ns/10ps
`include "rename_defines.svh"
`default_nettype none

module reorder_buffer import rename_pkg::*; (
    input  logic                          clk,
    input  logic                          rst_n_i,
    input  logic                          alloc_fire_i,
    input  logic [`RN_WIDTH-1:0]          alloc_valid_i,
    input  inst_class_e [`RN_WIDTH-1:0]   alloc_class_i,
    input  arch_idx_t [`RN_WIDTH-1:0]     alloc_rd_i,
    input  phys_idx_t [`RN_WIDTH-1:0]     alloc_new_i,
    input  phys_idx_t [`RN_WIDTH-1:0]     alloc_old_i,
    output rob_idx_t [`RN_WIDTH-1:0]      alloc_idx_o,
    output logic [ROB_CNT_W-1:0]          free_cnt_o,
    input  logic                          complete_valid_i,
    input  rob_idx_t                      complete_idx_i,
    input  logic                          flush_i,
    output logic [`RN_WIDTH-1:0]          head_valid_o,
    output logic [`RN_WIDTH-1:0]          head_rd_wen_o,
    output arch_idx_t [`RN_WIDTH-1:0]     head_arch_o,
    output phys_idx_t [`RN_WIDTH-1:0]     head_new_o,
    output phys_idx_t [`RN_WIDTH-1:0]     head_old_o
);

    inst_class_e              ent_class_q [`RN_ROB_DEPTH];
    arch_idx_t                ent_rd_q    [`RN_ROB_DEPTH];
    phys_idx_t                ent_new_q   [`RN_ROB_DEPTH];
    phys_idx_t                ent_old_q   [`RN_ROB_DEPTH];
    logic [`RN_ROB_DEPTH-1:0] ent_valid_q;
    logic [`RN_ROB_DEPTH-1:0] ent_done_q;
    rob_idx_t                 head_q;
    rob_idx_t                 tail_q;
    logic [ROB_CNT_W-1:0]     count_q;
    logic [ROB_CNT_W-1:0]     alloc_cnt;
    logic [ROB_CNT_W-1:0]     pop_cnt;
    rob_idx_t                 head_idx [`RN_WIDTH];

    assign free_cnt_o = ROB_CNT_W'(`RN_ROB_DEPTH) - count_q;

    // Valid slots are packed behind the tail in slot order.
    always_comb begin
        alloc_cnt = '0;
        for (int s = 0; s < `RN_WIDTH; s++) begin
            alloc_idx_o[s] = tail_q + rob_idx_t'(alloc_cnt);
            if (alloc_valid_i[s]) begin
                alloc_cnt = alloc_cnt + 1'b1;
            end
        end
    end

    // Only the done prefix of the head group is shown; a pending entry blocks the younger ones.
    always_comb begin
        logic in_order;
        in_order = 1'b1;
        pop_cnt  = '0;
        for (int k = 0; k < `RN_WIDTH; k++) begin
            head_idx[k]      = head_q + rob_idx_t'(k);
            in_order         = in_order && ent_valid_q[head_idx[k]] && ent_done_q[head_idx[k]];
            head_valid_o[k]  = in_order;
            head_rd_wen_o[k] = class_writes_rd(ent_class_q[head_idx[k]]);
            head_arch_o[k]   = ent_rd_q[head_idx[k]];
            head_new_o[k]    = ent_new_q[head_idx[k]];
            head_old_o[k]    = ent_old_q[head_idx[k]];
            if (in_order) begin
                pop_cnt = pop_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i || flush_i) begin
            ent_valid_q <= '0;
            ent_done_q  <= '0;
            head_q      <= '0;
            tail_q      <= '0;
            count_q     <= '0;
        end else begin
            for (int k = 0; k < `RN_WIDTH; k++) begin
                if (head_valid_o[k]) begin
                    ent_valid_q[head_idx[k]] <= 1'b0;
                end
            end
            if (alloc_fire_i) begin
                for (int s = 0; s < `RN_WIDTH; s++) begin
                    if (alloc_valid_i[s]) begin
                        ent_valid_q[alloc_idx_o[s]] <= 1'b1;
                        ent_done_q[alloc_idx_o[s]]  <= 1'b0;
                    end
                end
                tail_q <= tail_q + rob_idx_t'(alloc_cnt);
            end
            if (complete_valid_i && ent_valid_q[complete_idx_i]) begin
                ent_done_q[complete_idx_i] <= 1'b1;
            end
            head_q  <= head_q + rob_idx_t'(pop_cnt);
            count_q <= count_q + (alloc_fire_i ? alloc_cnt : '0) - pop_cnt;
        end
    end

    always_ff @(posedge clk) begin
        if (alloc_fire_i) begin
            for (int s = 0; s < `RN_WIDTH; s++) begin
                if (alloc_valid_i[s]) begin
                    ent_class_q[alloc_idx_o[s]] <= alloc_class_i[s];
                    ent_rd_q[alloc_idx_o[s]]    <= alloc_rd_i[s];
                    ent_new_q[alloc_idx_o[s]]   <= alloc_new_i[s];
                    ent_old_q[alloc_idx_o[s]]   <= alloc_old_i[s];
                end
            end
        end
    end

endmodule

`default_nettype wire

/* free_list.sv */
`timescale 1ns/10ps
`include "rename_defines.svh"
`default_nettype none

module free_list import rename_pkg::*; (
    input  logic                          clk,
    input  logic                          rst_n_i,
    input  logic [`RN_WIDTH-1:0]          alloc_req_i,
    input  logic                          alloc_fire_i,
    output phys_idx_t [`RN_WIDTH-1:0]     alloc_prd_o,
    input  logic [`RN_WIDTH-1:0]          free_valid_i,
    input  phys_idx_t [`RN_WIDTH-1:0]     free_reg_i,
    input  logic                          flush_i,
    input  logic [`RN_PHYS_REGS-1:0]      held_mask_i,
    output logic [FREE_CNT_W-1:0]         free_cnt_o
);

    logic [`RN_PHYS_REGS-1:0] free_q;
    logic [`RN_PHYS_REGS-1:0] free_d;
    phys_idx_t                cand [`RN_WIDTH];

    // Lowest free registers, one candidate per lane.
    always_comb begin
        int n;
        n = 0;
        for (int s = 0; s < `RN_WIDTH; s++) begin
            cand[s] = '0;
        end
        for (int i = 0; i < `RN_PHYS_REGS; i++) begin
            if (free_q[i] && (n < `RN_WIDTH)) begin
                cand[n] = phys_idx_t'(i);
                n++;
            end
        end
    end

    // Requesting slots take the candidates in order, so slot 0 gets the lowest.
    always_comb begin
        int k;
        k = 0;
        for (int s = 0; s < `RN_WIDTH; s++) begin
            alloc_prd_o[s] = cand[k];
            if (alloc_req_i[s]) begin
                k++;
            end
        end
    end

    always_comb begin
        free_d = free_q;
        if (alloc_fire_i) begin
            for (int s = 0; s < `RN_WIDTH; s++) begin
                if (alloc_req_i[s]) begin
                    free_d[alloc_prd_o[s]] = 1'b0;
                end
            end
        end
        for (int s = 0; s < `RN_WIDTH; s++) begin
            if (free_valid_i[s]) begin
                free_d[free_reg_i[s]] = 1'b1;
            end
        end
    end

    always_comb begin
        free_cnt_o = '0;
        for (int i = 0; i < `RN_PHYS_REGS; i++) begin
            free_cnt_o = free_cnt_o + FREE_CNT_W'(free_q[i]);
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            // The upper registers start free; the identity map holds the rest.
            free_q <= {{(`RN_PHYS_REGS - `RN_ARCH_REGS){1'b1}}, {`RN_ARCH_REGS{1'b0}}};
        end else if (flush_i) begin
            free_q <= ~held_mask_i; // Everything not committed comes back.
        end else begin
            free_q <= free_d;
        end
    end

endmodule

`default_nettype wire

/* rename_map.sv */
`timescale 1ns/10ps
`include "rename_defines.svh"
`default_nettype none

module rename_map import rename_pkg::*; (
    input  logic                          clk,
    input  logic                          rst_n_i,
    input  logic [`RN_WIDTH-1:0]          ren_valid_i,
    input  inst_class_e [`RN_WIDTH-1:0]   ren_class_i,
    input  arch_idx_t [`RN_WIDTH-1:0]     ren_rd_i,
    input  arch_idx_t [`RN_WIDTH-1:0]     ren_rs1_i,
    input  arch_idx_t [`RN_WIDTH-1:0]     ren_rs2_i,
    input  logic [ROB_CNT_W-1:0]          rob_free_cnt_i,
    input  logic [FREE_CNT_W-1:0]         fl_free_cnt_i,
    input  logic                          flush_i,
    input  phys_idx_t [`RN_ARCH_REGS-1:0] amt_map_i,
    input  phys_idx_t [`RN_WIDTH-1:0]     fl_alloc_prd_i,
    output logic                          ren_ready_o,
    output logic                          ren_fire_o,
    output logic [`RN_WIDTH-1:0]          fl_alloc_req_o,
    output phys_idx_t [`RN_WIDTH-1:0]     ren_prd_o,
    output phys_idx_t [`RN_WIDTH-1:0]     ren_old_prd_o,
    output phys_idx_t [`RN_WIDTH-1:0]     ren_prs1_o,
    output phys_idx_t [`RN_WIDTH-1:0]     ren_prs2_o
);

    phys_idx_t spec_map_q [`RN_ARCH_REGS];

    // Whole-group rename, so ready never looks at the valids.
    assign ren_ready_o = (rob_free_cnt_i >= ROB_CNT_W'(`RN_WIDTH)) &&
                         (fl_free_cnt_i >= FREE_CNT_W'(`RN_WIDTH)) && !flush_i;
    assign ren_fire_o  = ren_ready_o && (|ren_valid_i);

    always_comb begin
        for (int s = 0; s < `RN_WIDTH; s++) begin
            fl_alloc_req_o[s] = ren_valid_i[s] && class_writes_rd(ren_class_i[s]);
            ren_prd_o[s]      = fl_alloc_req_o[s] ? fl_alloc_prd_i[s] : '0;
        end
    end

    // Younger slots see the destinations renamed by older slots of the same group.
    always_comb begin
        for (int s = 0; s < `RN_WIDTH; s++) begin
            ren_prs1_o[s]    = spec_map_q[ren_rs1_i[s]];
            ren_prs2_o[s]    = spec_map_q[ren_rs2_i[s]];
            ren_old_prd_o[s] = spec_map_q[ren_rd_i[s]];
            for (int j = 0; j < s; j++) begin
                if (fl_alloc_req_o[j] && (ren_rd_i[j] == ren_rs1_i[s])) begin
                    ren_prs1_o[s] = ren_prd_o[j];
                end
                if (fl_alloc_req_o[j] && (ren_rd_i[j] == ren_rs2_i[s])) begin
                    ren_prs2_o[s] = ren_prd_o[j];
                end
                if (fl_alloc_req_o[j] && (ren_rd_i[j] == ren_rd_i[s])) begin
                    ren_old_prd_o[s] = ren_prd_o[j];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            for (int i = 0; i < `RN_ARCH_REGS; i++) begin
                spec_map_q[i] <= phys_idx_t'(i); // Identity map.
            end
        end else if (flush_i) begin
            for (int i = 0; i < `RN_ARCH_REGS; i++) begin
                spec_map_q[i] <= amt_map_i[i];
            end
        end else if (ren_fire_o) begin
            // Later slots are written last and win on a shared destination.
            for (int s = 0; s < `RN_WIDTH; s++) begin
                if (fl_alloc_req_o[s]) begin
                    spec_map_q[ren_rd_i[s]] <= ren_prd_o[s];
                end
            end
        end
    end

endmodule

`default_nettype wire

/* rename_pkg.sv */
`default_nettype none
`include "rename_defines.svh"

package rename_pkg;

    localparam int unsigned ARCH_W     = $clog2(`RN_ARCH_REGS);
    localparam int unsigned PHYS_W     = $clog2(`RN_PHYS_REGS);
    localparam int unsigned ROB_W      = $clog2(`RN_ROB_DEPTH);
    localparam int unsigned FREE_CNT_W = $clog2(`RN_PHYS_REGS + 1);
    localparam int unsigned ROB_CNT_W  = $clog2(`RN_ROB_DEPTH + 1);
    localparam int unsigned RET_CNT_W  = $clog2(`RN_WIDTH + 1);

    typedef logic [ARCH_W-1:0] arch_idx_t;
    typedef logic [PHYS_W-1:0] phys_idx_t;
    typedef logic [ROB_W-1:0]  rob_idx_t;

    typedef enum logic [1:0] {
        CLS_ALU,
        CLS_LOAD,
        CLS_STORE,
        CLS_BRANCH
    } inst_class_e;

    // Only ALU ops and loads produce a register result.
    function automatic logic class_writes_rd(input inst_class_e cls);
        return (cls == CLS_ALU) || (cls == CLS_LOAD);
    endfunction

endpackage

`default_nettype wire

/* rename_defines.svh */
`default_nettype none
`ifndef RENAME_DEFINES_SVH
`define RENAME_DEFINES_SVH

// Register file sizes.
`define RN_ARCH_REGS 32
`define RN_PHYS_REGS 64

`define RN_WIDTH     2   // Rename and commit lanes per cycle.
`define RN_ROB_DEPTH 16  // Must stay a power of two for pointer wrap.

`endif
`default_nettype wire
